// ==== build.f ====
+incdir+hw
hw/dcache_pkg.sv
hw/victim_lfsr.sv
hw/tag_store.sv
hw/line_store.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
testbench/clk_rst_gen.sv
testbench/tb_dcache.sv

// ==== testbench/dcache_stim.txt ====
// op(1=store) addr wstrb wdata expected_rdata expected_miss
// expected_miss: 0 hit, 1 line read, 2 either (victim dependent)
0 00001000 0 00000000 5A5A1000 1
0 00001008 0 00000000 5A5A1008 0
0 0000100C 0 00000000 5A5A100C 0
1 00001004 1 000000AB 00000000 0
0 00001004 0 00000000 5A5A10AB 0
1 00001008 C BEEF0000 00000000 0
0 00001008 0 00000000 BEEF1008 0
1 0000100C F 12345678 00000000 0
0 0000100C 0 00000000 12345678 0
1 00002024 2 0000CD00 00000000 0
0 00002024 0 00000000 5A5ACD24 1
0 00002020 0 00000000 5A5A2020 0
1 00002028 3 00009876 00000000 0
0 00002028 0 00000000 5A5A9876 0
0 00010300 0 00000000 5A5B0300 1
0 00020304 0 00000000 5A580304 1
0 00030308 0 00000000 5A590308 1
0 0001030C 0 00000000 5A5B030C 2
0 00020308 0 00000000 5A580308 2
1 00030304 4 00770000 00000000 0
0 00030304 0 00000000 5A770304 2
0 00010300 0 00000000 5A5B0300 2
0 00020300 0 00000000 5A580300 2
0 00030300 0 00000000 5A590300 2
0 00030304 0 00000000 5A770304 2
1 00020300 F CAFEF00D 00000000 0
0 00020300 0 00000000 CAFEF00D 2
0 0001030C 0 00000000 5A5B030C 2
0 0000100C 0 00000000 12345678 0
1 00010308 1 000000EE 00000000 0
0 00010308 0 00000000 5A5B03EE 2

// ==== testbench/tb_dcache.sv ====
`timescale 1ns/1ps

module tb_dcache
    import dcache_pkg::*;
;

    localparam int    MAX_REQ   = 64;
    localparam int    FIELDS    = 6;
    localparam word_t FILL_MASK = 32'h5A5A0000;

    logic     clk;
    logic     rst;
    logic     valid;
    cpu_req_t req;
    logic     ready;
    logic     data_ok;
    word_t    rdata;
    logic     rd_req;
    addr_t    rd_addr;
    logic     rd_rdy;
    logic     ret_valid;
    line_t    ret_data;
    logic     wr_req;
    mem_wr_t  wr;
    logic     wr_rdy;

    logic [31:0] stim [0:MAX_REQ*FIELDS-1];
    word_t       mem_words [addr_t];  // only words that were stored
    addr_t       cur_addr;
    wstrb_t      cur_wstrb;
    word_t       cur_wdata;
    int          n_req;
    int          rd_count;
    int          wr_count;
    int          check_count;
    int          error_count;
    int          cycle_count;
    int          timeout_limit = 1000000;
    logic [31:0] lcg_state = 32'd47;

    clk_rst_gen u_clk_rst (
        .clk (clk),
        .rst (rst)
    );

    dcache_top uut (
        .clk       (clk),
        .rst       (rst),
        .valid     (valid),
        .req       (req),
        .ready     (ready),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr        (wr),
        .wr_rdy    (wr_rdy)
    );

    function automatic int next_stall();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'(lcg_state[18:16]);  // 0 to 7 cycles
    endfunction

    function automatic word_t mem_word(input addr_t a);
        addr_t wa;
        wa = {a[31:2], 2'b00};
        if (mem_words.exists(wa)) return mem_words[wa];
        return wa ^ FILL_MASK;
    endfunction

    function automatic line_t read_line(input addr_t a);
        line_t l;
        for (int k = 0; k < 4; k++) l[32*k +: 32] = mem_word({a[31:4], 4'h0} + 4 * k);
        return l;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic report_problem(input string msg);
        error_count++;
        $display("error at %0t: %s", $time, msg);
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // byte merge of the requested store into the memory image
    task automatic merge_write(input addr_t a, input wstrb_t s, input word_t d);
        addr_t wa;
        word_t merged;
        wa     = {a[31:2], 2'b00};
        merged = mem_word(wa);
        for (int b = 0; b < 4; b++) begin
            if (s[b]) merged[8*b +: 8] = d[8*b +: 8];
        end
        mem_words[wa] = merged;
    endtask

    task automatic serve_read();
        addr_t line_addr;
        wait_cycles(next_stall());
        line_addr = rd_addr;
        check_value("rd_addr", rd_addr, {cur_addr[31:4], 4'h0});
        rd_count++;
        rd_rdy = 1'b1;
        wait_cycles(1);
        rd_rdy = 1'b0;
        wait_cycles(next_stall());
        ret_data  = read_line(line_addr);
        ret_valid = 1'b1;
        wait_cycles(1);
        ret_valid = 1'b0;
    endtask

    task automatic serve_write();
        logic [1:0] lane;
        wait_cycles(next_stall());
        lane = cur_addr[3:2];
        check_value("wr.addr", wr.addr, cur_addr);
        check_value("wr.wstrb", wr.wstrb, line_strb_t'(cur_wstrb) << (4 * lane));
        check_value("wr.data", wr.data[32*lane +: 32], cur_wdata);
        merge_write(cur_addr, cur_wstrb, cur_wdata);
        wr_count++;
        wr_rdy = 1'b1;
        wait_cycles(1);
        wr_rdy = 1'b0;
    endtask

    task automatic run_request(input int idx);
        logic  op;
        logic  accepted;
        word_t exp_rdata;
        int    exp_miss;
        int    lat;
        int    rd_before;
        int    wr_before;
        op        = stim[FIELDS*idx][0];
        cur_addr  = stim[FIELDS*idx + 1];
        cur_wstrb = stim[FIELDS*idx + 2][3:0];
        cur_wdata = stim[FIELDS*idx + 3];
        exp_rdata = stim[FIELDS*idx + 4];
        exp_miss  = int'(stim[FIELDS*idx + 5]);
        rd_before = rd_count;
        wr_before = wr_count;
        valid     = 1'b1;
        req.op    = op;
        req.addr  = cur_addr;
        req.wstrb = cur_wstrb;
        req.wdata = cur_wdata;
        accepted  = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = ready;
            wait_cycles(1);
        end
        valid = 1'b0;
        req   = '0;
        lat   = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!data_ok);
        if (op) begin
            if (rd_count != rd_before) report_problem($sformatf("store %0d read a line", idx));
            if (wr_count != wr_before + 1)
                report_problem($sformatf("store %0d did not write memory once", idx));
        end else begin
            check_value("rdata", rdata, exp_rdata);
            check_value("rdata vs memory", rdata, mem_word(cur_addr));
            if (wr_count != wr_before) report_problem($sformatf("load %0d wrote memory", idx));
            if (exp_miss == 1 && rd_count != rd_before + 1)
                report_problem($sformatf("load %0d should miss but read no line", idx));
            if (exp_miss == 0 && rd_count != rd_before)
                report_problem($sformatf("load %0d should hit but read a line", idx));
            if (exp_miss == 0 && lat != 1)
                report_problem($sformatf("load hit %0d took %0d cycles, not 1", idx, lat));
        end
        wait_cycles(1);
    endtask

    initial begin : read_model
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_data  = '0;
        forever begin
            wait_cycles(1);
            if (!rst && rd_req) serve_read();
        end
    end

    initial begin : write_model
        wr_rdy = 1'b0;
        forever begin
            wait_cycles(1);
            if (!rst && wr_req) serve_write();
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > timeout_limit) begin
            error_count++;
            $display("timeout after %0d cycles, the cache stopped answering", cycle_count);
            $display("checks %0d, errors %0d", check_count, error_count);
            $display("Test failed");
            $finish;
        end
    end

    initial begin : stimulus
        valid = 1'b0;
        req   = '0;
        for (int k = 0; k < MAX_REQ * FIELDS; k++) stim[k] = '1;
        $readmemh("testbench/dcache_stim.txt", stim);
        n_req = 0;
        while (n_req < MAX_REQ && stim[FIELDS*n_req] != 32'hFFFFFFFF) n_req++;
        timeout_limit = n_req * 30 + 400;
        if (n_req == 0) report_problem("no requests found in the stimulus file");
        do @(negedge clk); while (rst || !ready);  // reset sweep
        wait_cycles(1);
        for (int i = 0; i < n_req; i++) run_request(i);
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== testbench/clk_rst_gen.sv ====
`timescale 1ns/1ps

module clk_rst_gen #(
    parameter real PERIOD     = 20.0,
    parameter int  RST_CYCLES = 4
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

    // release just after an edge, like the rest of the stimulus
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

// ==== hw/dcache_top.sv ====
`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_top
    import dcache_pkg::*;
(
    input  logic     clk,
    input  logic     rst,

    input  logic     valid,
    input  cpu_req_t req,
    output logic     ready,
    output logic     data_ok,
    output word_t    rdata,

    output logic     rd_req,
    output addr_t    rd_addr,
    input  logic     rd_rdy,
    input  logic     ret_valid,
    input  line_t    ret_data,

    output logic     wr_req,
    output mem_wr_t  wr,
    input  logic     wr_rdy
);

    index_t     arr_index;
    logic       arr_rd_en;
    way_vec_t   tag_we;
    tag_entry_t tag_wdata;
    way_vec_t   line_we;
    line_t      line_wdata;
    line_strb_t line_wstrb;
    way_vec_t   hit_way;
    line_t      hit_line;
    logic       victim;

    dcache_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .valid      (valid),
        .req        (req),
        .ready      (ready),
        .data_ok    (data_ok),
        .rdata      (rdata),
        .rd_req     (rd_req),
        .rd_addr    (rd_addr),
        .rd_rdy     (rd_rdy),
        .ret_valid  (ret_valid),
        .ret_data   (ret_data),
        .wr_req     (wr_req),
        .wr         (wr),
        .wr_rdy     (wr_rdy),
        .arr_index  (arr_index),
        .arr_rd_en  (arr_rd_en),
        .tag_we     (tag_we),
        .tag_wdata  (tag_wdata),
        .line_we    (line_we),
        .line_wdata (line_wdata),
        .line_wstrb (line_wstrb),
        .hit_way    (hit_way),
        .hit_line   (hit_line),
        .victim     (victim)
    );

    // write value always carries the buffered tag, so it doubles as the compare tag
    tag_store #(
        .NSET (`DCACHE_NSET)
    ) u_tag_store (
        .clk     (clk),
        .rd_en   (arr_rd_en),
        .index   (arr_index),
        .we      (tag_we),
        .wdata   (tag_wdata),
        .cmp_tag (tag_wdata.tag),
        .hit_way (hit_way)
    );

    line_store #(
        .NSET (`DCACHE_NSET)
    ) u_line_store (
        .clk      (clk),
        .rd_en    (arr_rd_en),
        .index    (arr_index),
        .we       (line_we),
        .wdata    (line_wdata),
        .wstrb    (line_wstrb),
        .hit_way  (hit_way),
        .hit_line (hit_line)
    );

    victim_lfsr #(
        .SEED (`DCACHE_LFSR_SEED)
    ) u_victim_lfsr (
        .clk    (clk),
        .rst    (rst),
        .victim (victim)
    );

endmodule

// ==== hw/dcache_ctrl.sv ====
`timescale 1ns/1ps

module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    input  logic       valid,
    input  cpu_req_t   req,
    output logic       ready,
    output logic       data_ok,
    output word_t      rdata,

    output logic       rd_req,
    output addr_t      rd_addr,
    input  logic       rd_rdy,
    input  logic       ret_valid,
    input  line_t      ret_data,

    output logic       wr_req,
    output mem_wr_t    wr,
    input  logic       wr_rdy,

    output index_t     arr_index,
    output logic       arr_rd_en,
    output way_vec_t   tag_we,
    output tag_entry_t tag_wdata,
    output way_vec_t   line_we,
    output line_t      line_wdata,
    output line_strb_t line_wstrb,
    input  way_vec_t   hit_way,
    input  line_t      hit_line,
    input  logic       victim
);

    localparam int OFF_W  = $bits(offset_t);
    localparam int IDX_W  = $bits(index_t);
    localparam int TAG_W  = $bits(tag_t);
    localparam int ADDR_W = $bits(addr_t);
    localparam int WORD_W = $bits(word_t);
    localparam int NLANE  = $bits(line_t) / WORD_W;

    ctrl_state_e      state, next_state;
    cpu_req_t         req_q;
    logic             sweep_busy;
    index_t           sweep_cnt;
    logic             accept;
    logic             hit;
    logic [OFF_W-3:0] lane;
    way_vec_t         victim_way;
    index_t           req_index;
    index_t           buf_index;
    line_t            src_line;

    assign req_index  = req.addr[OFF_W +: IDX_W];
    assign buf_index  = req_q.addr[OFF_W +: IDX_W];
    assign lane       = req_q.addr[OFF_W-1:2];
    assign hit        = |hit_way;
    assign victim_way = way_vec_t'(1) << victim;

    assign ready  = (state == IDLE) && !sweep_busy;
    assign accept = valid && ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // invalidate every set once after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            sweep_busy <= 1'b1;
            sweep_cnt  <= '0;
        end else if (sweep_busy) begin
            sweep_cnt <= sweep_cnt + 1'b1;
            if (sweep_cnt == '1) sweep_busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) req_q <= req;
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE:      if (accept) next_state = LOOKUP;
            LOOKUP: begin
                if (req_q.op) next_state = WRITE_REQ;  // write-through, hit or miss
                else if (hit) next_state = IDLE;
                else          next_state = READ_REQ;
            end
            READ_REQ:  if (rd_rdy) next_state = READ_WAIT;
            READ_WAIT: if (ret_valid) next_state = IDLE;
            WRITE_REQ: if (wr_rdy) next_state = IDLE;
            default:   next_state = IDLE;
        endcase
    end

    assign rd_req  = (state == READ_REQ);
    assign rd_addr = {req_q.addr[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
    assign wr_req  = (state == WRITE_REQ);

    always_comb begin
        wr.addr  = req_q.addr;  // unaligned, memory picks the lane
        wr.wstrb = line_strb_t'(req_q.wstrb) << {lane, 2'b00};
        wr.data  = {NLANE{req_q.wdata}};
    end

    assign data_ok = (state == LOOKUP && !req_q.op && hit)
                  || (state == READ_WAIT && ret_valid)
                  || (state == WRITE_REQ && wr_rdy);

    assign src_line = (state == LOOKUP) ? hit_line : ret_data;
    assign rdata    = src_line[lane*WORD_W +: WORD_W];

    always_comb begin
        arr_index = buf_index;
        if (sweep_busy) begin
            arr_index = sweep_cnt;
        end else if (state == IDLE) begin
            arr_index = req_index;  // read on the accept edge
        end
        arr_rd_en = accept;

        tag_wdata.valid = !sweep_busy;
        tag_wdata.tag   = req_q.addr[ADDR_W-1 -: TAG_W];
        tag_we          = '0;
        line_we         = '0;
        line_wdata      = wr.data;
        line_wstrb      = wr.wstrb;

        if (sweep_busy) begin
            tag_we = '1;
        end else if (state == READ_WAIT && ret_valid) begin
            tag_we     = victim_way;  // refill
            line_we    = victim_way;
            line_wdata = ret_data;
            line_wstrb = '1;
        end else if (state == WRITE_REQ && wr_rdy) begin
            line_we = hit_way;  // no allocate on store miss
        end
    end

    a_rd_wr_excl : assert property (
        @(posedge clk) disable iff (rst) !(rd_req && wr_req)
    );

    // read request must hold until memory takes it
    a_rd_req_hold : assert property (
        @(posedge clk) disable iff (rst)
        rd_req && !rd_rdy |=> rd_req && $stable(rd_addr)
    );

endmodule

// ==== hw/line_store.sv ====
`timescale 1ns/1ps

module line_store
    import dcache_pkg::*;
#(
    parameter int NSET
) (
    input  logic       clk,
    input  logic       rd_en,
    input  index_t     index,
    input  way_vec_t   we,
    input  line_t      wdata,
    input  line_strb_t wstrb,
    input  way_vec_t   hit_way,
    output line_t      hit_line
);

    localparam int NWAY  = $bits(way_vec_t);
    localparam int NBYTE = $bits(line_strb_t);

    line_t rd_q [NWAY];

    for (genvar w = 0; w < NWAY; w++) begin : g_way
        line_t mem [NSET];

        always_ff @(posedge clk) begin
            if (we[w]) begin
                for (int b = 0; b < NBYTE; b++) begin
                    if (wstrb[b]) mem[index][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
            if (rd_en) rd_q[w] <= mem[index];
        end
    end

    // and-or mux, hit_way is at most one-hot
    always_comb begin
        hit_line = '0;
        for (int w = 0; w < NWAY; w++) begin
            if (hit_way[w]) hit_line = hit_line | rd_q[w];
        end
    end

endmodule

// ==== hw/tag_store.sv ====
`timescale 1ns/1ps

module tag_store
    import dcache_pkg::*;
#(
    parameter int NSET
) (
    input  logic       clk,
    input  logic       rd_en,
    input  index_t     index,
    input  way_vec_t   we,
    input  tag_entry_t wdata,
    input  tag_t       cmp_tag,
    output way_vec_t   hit_way
);

    localparam int NWAY = $bits(way_vec_t);

    tag_entry_t rd_q [NWAY];

    for (genvar w = 0; w < NWAY; w++) begin : g_way
        tag_entry_t mem [NSET];

        always_ff @(posedge clk) begin
            if (we[w]) mem[index] <= wdata;
            if (rd_en) rd_q[w] <= mem[index];  // held until next lookup
        end

        assign hit_way[w] = rd_q[w].valid && (rd_q[w].tag == cmp_tag);
    end

    // a line never lives in two ways, since refill only follows a miss
    a_hit_onehot : assert property (
        @(posedge clk) $past(rd_en) |-> $onehot0(hit_way)
    );

endmodule

// ==== hw/victim_lfsr.sv ====
`timescale 1ns/1ps

module victim_lfsr #(
    parameter logic [15:0] SEED
) (
    input  logic clk,
    input  logic rst,
    output logic victim
);

    // x^16 + x^14 + x^13 + x^11 + 1, right-shifting Galois form
    localparam logic [15:0] TAPS = 16'hB400;

    logic [15:0] lfsr;

    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr <= SEED;
        end else begin
            lfsr <= {1'b0, lfsr[15:1]} ^ (lfsr[0] ? TAPS : 16'h0000);
        end
    end

    assign victim = lfsr[0];  // refill way

endmodule

// ==== hw/dcache_pkg.sv ====
`include "dcache_macros.svh"

package dcache_pkg;

    typedef logic [31:0]                    addr_t;
    typedef logic [31:0]                    word_t;
    typedef logic [3:0]                     wstrb_t;
    typedef logic [`DCACHE_TAG_W-1:0]       tag_t;
    typedef logic [`DCACHE_INDEX_W-1:0]     index_t;
    typedef logic [`DCACHE_OFFSET_W-1:0]    offset_t;
    typedef logic [`DCACHE_LINE_W-1:0]      line_t;
    typedef logic [`DCACHE_LINE_W/8-1:0]    line_strb_t;
    typedef logic [`DCACHE_NWAY-1:0]        way_vec_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_entry_t;

    typedef struct packed {
        logic   op;     // 1 = store
        addr_t  addr;
        wstrb_t wstrb;
        word_t  wdata;
    } cpu_req_t;

    // word write placed in its lane of a line-wide beat
    typedef struct packed {
        addr_t      addr;
        line_strb_t wstrb;
        line_t      data;
    } mem_wr_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        READ_REQ,
        READ_WAIT,
        WRITE_REQ
    } ctrl_state_e;

endpackage

// ==== hw/dcache_macros.svh ====
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// geometry
`define DCACHE_NWAY      2
`define DCACHE_NSET      256
`define DCACHE_TAG_W     20
`define DCACHE_INDEX_W   8
`define DCACHE_OFFSET_W  4

// one line is also one memory read beat
`define DCACHE_LINE_W    128

// must be nonzero
`define DCACHE_LFSR_SEED 16'hACE1

`endif
